// ==== motion_defs.svh ====
// Shared widths, counts, command codes and reset defaults; included by the package and the RTL
`ifndef MOTION_DEFS_SVH
`define MOTION_DEFS_SVH

// Bus and axis counts
`define WORD_BITS 64
`define NUM_MOTORS 2
`define BUFFER_SIZE 2     // Must be a power of two

// Datapath widths
`define DDA_BITS 32
`define DURATION_BITS 32
`define POSITION_BITS 32
`define DIVISOR_BITS 8

// DDA clock divisor after reset
`define DEFAULT_DIVISOR 32

// Command header codes (top byte of the first word)
`define CMD_COORDINATED_STEP 8'h01
`define CMD_STATUS_REG 8'hf1
`define CMD_CONFIG_REG 8'hf2

// Version word bytes
`define VERSION_MAJOR 8'd0
`define VERSION_MINOR 8'd3
`define VERSION_PATCH 8'd1

`endif

// ==== motion_pkg.sv ====
// Shared vector types and the sequencer state enum; imported by the motion engine modules
`default_nettype none

`include "motion_defs.svh"

package motion_pkg;

  // One full bus word
  typedef logic [`WORD_BITS-1:0] word_t;

  // Signed DDA rate, also used for the rate ramp
  typedef logic signed [`DDA_BITS-1:0] rate_t;

  // Move length counted in DDA ticks
  typedef logic [`DURATION_BITS-1:0] duration_t;

  // Signed step count per axis
  typedef logic signed [`POSITION_BITS-1:0] position_t;

  typedef logic [`DIVISOR_BITS-1:0] divisor_t;  // System clocks per DDA tick

  // One bit per axis for enable and direction
  typedef logic [`NUM_MOTORS-1:0] motor_mask_t;

  // Index into the move buffer
  typedef logic [$clog2(`BUFFER_SIZE)-1:0] slot_t;

  typedef logic [7:0] header_t;  // Command code

  // Move sequencer states
  typedef enum logic [1:0] {
    SEQ_IDLE,  // Waiting for a pending slot
    SEQ_LOAD,  // Timers latch the new rates
    SEQ_RUN,   // Counting down DDA ticks
    SEQ_DONE   // Retire the slot
  } seq_state_t;

endpackage

`default_nettype wire

// ==== spi_command_decoder.sv ====
// Word-level command decoder fed by the SPI core; fills the move buffer and serves status/config
`default_nettype none

`include "motion_defs.svh"

module spi_command_decoder (
  input  logic                   CLK,
  input  logic                   resetn,
  input  logic                   word_received,
  input  motion_pkg::word_t      word_data_received,
  output motion_pkg::word_t      word_send_data,
  input  logic                   buffer_dtr,
  output motion_pkg::slot_t      wr_slot,
  output logic                   wr_en,
  output logic [2:0]             wr_index,
  output motion_pkg::word_t      wr_data,
  output logic                   dir_wr,
  output logic                   commit,
  input  motion_pkg::position_t  position [`NUM_MOTORS],
  output motion_pkg::motor_mask_t enable,
  output motion_pkg::divisor_t   divisor
);
  import motion_pkg::*;

  // Index of the last payload word of a move
  localparam int LAST_WORD = 1 + 2 * `NUM_MOTORS;

  logic       word_received_q;
  logic       word_rise;     // One cycle after the strobe rises
  header_t    msg_header;    // Zero while waiting for a header
  header_t    new_header;
  logic [7:0] hdr_addr;
  logic [7:0] reg_addr;      // Config register chosen by the header
  logic [2:0] word_count;
  logic       move_drop;     // Move arrived with the buffer full
  logic       commit_q;
  word_t      status_word;
  word_t      config_word;

  assign new_header = word_data_received[`WORD_BITS-1 -: 8];
  assign hdr_addr   = word_data_received[7:0];

  // Edge detect on the word strobe
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      word_received_q <= 1'b0;
      word_rise       <= 1'b0;
    end else begin
      word_received_q <= word_received;
      word_rise       <= word_received & ~word_received_q;
    end
  end

  // Read-only status words
  always_comb begin
    status_word = '0;
    if (hdr_addr == 8'd0) begin
      status_word[23:0] = {`VERSION_MAJOR, `VERSION_MINOR, `VERSION_PATCH};
    end else if (hdr_addr == 8'd1) begin
      status_word[15:0] = {8'(`WORD_BITS), 8'(`NUM_MOTORS)};
    end
    for (int m = 0; m < `NUM_MOTORS; m++) begin
      if (hdr_addr == 8'(2 + m)) begin
        status_word = word_t'(position[m]);  // Sign extended
      end
    end
  end

  always_comb begin
    config_word = '0;
    case (hdr_addr)
      8'd0: config_word[`NUM_MOTORS-1:0] = enable;
      8'd1: config_word[`DIVISOR_BITS-1:0] = divisor;
      default: ;
    endcase
  end

  // Buffer write strobes go out in the update cycle
  assign wr_en    = word_rise && (msg_header == `CMD_COORDINATED_STEP) && !move_drop;
  assign wr_index = word_count;
  assign wr_data  = word_data_received;
  assign dir_wr   = word_rise && (msg_header == '0) &&
                    (new_header == `CMD_COORDINATED_STEP) && buffer_dtr;
  assign commit   = commit_q;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      word_send_data <= '0;
      msg_header     <= '0;
      word_count     <= '0;
      reg_addr       <= '0;
      move_drop      <= 1'b0;
      commit_q       <= 1'b0;
      enable         <= '0;
      divisor        <= divisor_t'(`DEFAULT_DIVISOR);
    end else begin
      commit_q <= 1'b0;
      if (word_rise) begin
        word_send_data <= '0;
        if (msg_header == '0) begin
          // New transaction
          msg_header <= new_header;
          word_count <= 3'd1;
          reg_addr   <= hdr_addr;
          case (new_header)
            `CMD_COORDINATED_STEP: move_drop <= !buffer_dtr;
            `CMD_STATUS_REG:       word_send_data <= status_word;
            `CMD_CONFIG_REG:       word_send_data <= config_word;
            default: ;
          endcase
        end else begin
          word_count <= word_count + 3'd1;
          case (msg_header)
            `CMD_COORDINATED_STEP: begin
              if (word_count == 3'(LAST_WORD)) begin
                msg_header <= '0;
                word_count <= '0;
                commit_q   <= !move_drop;  // Dropped moves never commit
                move_drop  <= 1'b0;
              end
            end
            `CMD_CONFIG_REG: begin
              // Write from the low half of the second word
              if (reg_addr == 8'd0) begin
                enable <= word_data_received[`NUM_MOTORS-1:0];
              end else if (reg_addr == 8'd1) begin
                divisor <= word_data_received[`DIVISOR_BITS-1:0];
              end
              msg_header <= '0;
              word_count <= '0;
            end
            default: begin
              msg_header <= '0;  // Two-word transaction ends here
              word_count <= '0;
            end
          endcase
        end
      end
    end
  end

  // Next slot once a move is committed
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      wr_slot <= '0;
    end else if (commit_q) begin
      wr_slot <= wr_slot + slot_t'(1);
    end
  end

  a_wr_index_range: assert property (@(posedge CLK) disable iff (!resetn)
    wr_en |-> (wr_index >= 3'd1 && wr_index <= 3'(LAST_WORD)));

endmodule

`default_nettype wire

// ==== move_buffer.sv ====
// Two-slot move storage written by the decoder and read by the sequencer and DDA timers
`default_nettype none

`include "motion_defs.svh"

module move_buffer (
  input  logic                    CLK,
  input  logic                    resetn,
  input  motion_pkg::slot_t       wr_slot,
  input  logic                    wr_en,
  input  logic [2:0]              wr_index,
  input  motion_pkg::word_t       wr_data,
  input  logic                    dir_wr,
  input  logic                    commit,
  input  motion_pkg::slot_t       rd_slot,
  output logic [`BUFFER_SIZE-1:0] slot_ready,
  output motion_pkg::duration_t   move_duration,
  output motion_pkg::rate_t       increment [`NUM_MOTORS],
  output motion_pkg::rate_t       increment_increment [`NUM_MOTORS],
  output motion_pkg::motor_mask_t dir
);
  import motion_pkg::*;

  localparam int MOVE_WORDS = 1 + 2 * `NUM_MOTORS;

  // Word 0 is the duration, then increment and ramp per axis
  word_t       move_words [`BUFFER_SIZE][MOVE_WORDS];
  motor_mask_t dir_mem [`BUFFER_SIZE];

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      move_words[wr_slot][wr_index - 3'd1] <= wr_data;  // Bus index starts at 1
    end
    if (dir_wr) begin
      dir_mem[wr_slot] <= wr_data[`NUM_MOTORS-1:0];
    end
  end

  // Ready flags toggle once per committed move
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      slot_ready <= '0;
    end else if (commit) begin
      slot_ready[wr_slot] <= ~slot_ready[wr_slot];
    end
  end

  assign move_duration = move_words[rd_slot][0][`DURATION_BITS-1:0];
  assign dir           = dir_mem[rd_slot];

  for (genvar m = 0; m < `NUM_MOTORS; m++) begin : g_axis
    assign increment[m]           = move_words[rd_slot][1 + 2 * m][`DDA_BITS-1:0];
    assign increment_increment[m] = move_words[rd_slot][2 + 2 * m][`DDA_BITS-1:0];
  end

  a_commit_after_words: assert property (@(posedge CLK) disable iff (!resetn)
    !(commit && wr_en));

endmodule

`default_nettype wire

// ==== move_sequencer.sv ====
// DDA tick generator and the FSM that loads, times and retires buffered moves
`default_nettype none

`include "motion_defs.svh"

module move_sequencer (
  input  logic                    CLK,
  input  logic                    resetn,
  input  motion_pkg::divisor_t    divisor,
  input  logic [`BUFFER_SIZE-1:0] slot_ready,
  input  motion_pkg::duration_t   move_duration,
  output motion_pkg::slot_t       rd_slot,
  input  motion_pkg::slot_t       wr_slot,
  output logic                    buffer_dtr,
  output logic                    dda_tick,
  output logic                    loading_move,
  output logic                    executing_move,
  output logic                    move_done
);
  import motion_pkg::*;

  divisor_t                tick_count;
  divisor_t                div_eff;     // Divisor of 0 runs like 1
  seq_state_t              state;
  duration_t               ticks_left;
  logic [`BUFFER_SIZE-1:0] slot_done;   // Toggled when a slot retires
  logic                    rd_pending;

  assign div_eff = (divisor == '0) ? divisor_t'(1) : divisor;

  // One tick every div_eff clocks
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      tick_count <= '0;
      dda_tick   <= 1'b0;
    end else if (tick_count >= div_eff - divisor_t'(1)) begin
      tick_count <= '0;
      dda_tick   <= 1'b1;
    end else begin
      tick_count <= tick_count + divisor_t'(1);
      dda_tick   <= 1'b0;
    end
  end

  // Pending means ready and done flags disagree
  assign rd_pending = slot_ready[rd_slot] ^ slot_done[rd_slot];
  assign buffer_dtr = ~(slot_ready[wr_slot] ^ slot_done[wr_slot]);

  assign loading_move   = (state == SEQ_LOAD);
  assign executing_move = (state == SEQ_RUN);
  assign move_done      = (state == SEQ_DONE);

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state      <= SEQ_IDLE;
      ticks_left <= '0;
      slot_done  <= '0;
      rd_slot    <= '0;
    end else begin
      case (state)
        SEQ_IDLE: begin
          if (rd_pending) begin
            state <= SEQ_LOAD;
          end
        end
        SEQ_LOAD: begin
          ticks_left <= move_duration;
          state      <= (move_duration == '0) ? SEQ_DONE : SEQ_RUN;
        end
        SEQ_RUN: begin
          if (dda_tick) begin
            if (ticks_left == duration_t'(1)) begin
              state <= SEQ_DONE;  // Last tick of the move
            end
            ticks_left <= ticks_left - duration_t'(1);
          end
        end
        SEQ_DONE: begin
          slot_done[rd_slot] <= ~slot_done[rd_slot];
          rd_slot            <= rd_slot + slot_t'(1);
          state              <= SEQ_IDLE;
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  // No commit lands in the slot being loaded or run
  a_active_slot_pending: assert property (@(posedge CLK) disable iff (!resetn)
    (loading_move || executing_move) |-> rd_pending);

endmodule

`default_nettype wire

// ==== dda_timer.sv ====
// Per-axis DDA timer with rate ramp, step pulse and signed step position
`default_nettype none

`include "motion_defs.svh"

module dda_timer (
  input  logic                  CLK,
  input  logic                  resetn,
  input  logic                  dda_tick,
  input  logic                  loading_move,
  input  logic                  executing_move,
  input  motion_pkg::rate_t     increment,
  input  motion_pkg::rate_t     increment_increment,
  input  logic                  dir_bit,
  output logic                  step,
  output motion_pkg::position_t position
);
  import motion_pkg::*;

  logic [`DDA_BITS-1:0] accum;
  rate_t                rate;   // Current rate, ramps each tick
  logic [`DDA_BITS:0]   sum;    // Carry in the top bit
  logic                 advance;

  // Unsigned add so the carry marks a step
  assign sum     = {1'b0, accum} + {1'b0, rate};
  assign advance = dda_tick && executing_move;

  assign step = advance && sum[`DDA_BITS];

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      accum <= '0;
      rate  <= '0;
    end else if (loading_move) begin
      // Fresh move
      accum <= '0;
      rate  <= increment;
    end else if (advance) begin
      accum <= sum[`DDA_BITS-1:0];
      rate  <= rate + increment_increment;
    end
  end

  // Position follows every emitted step
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      position <= '0;
    end else if (step) begin
      if (dir_bit) begin
        position <= position + position_t'(1);
      end else begin
        position <= position - position_t'(1);  // Reverse
      end
    end
  end

endmodule

`default_nettype wire

// ==== motion_core.sv ====
// Top level of the stepper command engine; connects decoder, buffer, sequencer and axis timers
`default_nettype none

`include "motion_defs.svh"

module motion_core (
  input  logic                         CLK,
  input  logic                         resetn,
  input  logic                         word_received,
  input  motion_pkg::word_t            word_data_received,
  output motion_pkg::word_t            word_send_data,
  output logic                         buffer_dtr,
  output logic                         move_done,
  output wire motion_pkg::motor_mask_t step,
  output motion_pkg::motor_mask_t      dir,
  output motion_pkg::motor_mask_t      enable
);
  import motion_pkg::*;

  // Decoder to buffer
  slot_t      wr_slot;
  logic       wr_en;
  logic [2:0] wr_index;
  word_t      wr_data;
  logic       dir_wr;
  logic       commit;

  // Buffer to sequencer and timers
  slot_t                   rd_slot;
  logic [`BUFFER_SIZE-1:0] slot_ready;
  duration_t               move_duration;
  rate_t                   increment [`NUM_MOTORS];
  rate_t                   increment_increment [`NUM_MOTORS];

  divisor_t divisor;
  logic     dda_tick;
  logic     loading_move;
  logic     executing_move;

  wire position_t position [`NUM_MOTORS];  // One driver per axis

  spi_command_decoder u_decoder (
    .CLK                (CLK),
    .resetn             (resetn),
    .word_received      (word_received),
    .word_data_received (word_data_received),
    .word_send_data     (word_send_data),
    .buffer_dtr         (buffer_dtr),
    .wr_slot            (wr_slot),
    .wr_en              (wr_en),
    .wr_index           (wr_index),
    .wr_data            (wr_data),
    .dir_wr             (dir_wr),
    .commit             (commit),
    .position           (position),
    .enable             (enable),
    .divisor            (divisor)
  );

  move_buffer u_buffer (
    .CLK                 (CLK),
    .resetn              (resetn),
    .wr_slot             (wr_slot),
    .wr_en               (wr_en),
    .wr_index            (wr_index),
    .wr_data             (wr_data),
    .dir_wr              (dir_wr),
    .commit              (commit),
    .rd_slot             (rd_slot),
    .slot_ready          (slot_ready),
    .move_duration       (move_duration),
    .increment           (increment),
    .increment_increment (increment_increment),
    .dir                 (dir)
  );

  move_sequencer u_sequencer (
    .CLK            (CLK),
    .resetn         (resetn),
    .divisor        (divisor),
    .slot_ready     (slot_ready),
    .move_duration  (move_duration),
    .rd_slot        (rd_slot),
    .wr_slot        (wr_slot),
    .buffer_dtr     (buffer_dtr),
    .dda_tick       (dda_tick),
    .loading_move   (loading_move),
    .executing_move (executing_move),
    .move_done      (move_done)
  );

  for (genvar m = 0; m < `NUM_MOTORS; m++) begin : g_axis
    dda_timer u_dda (
      .CLK                 (CLK),
      .resetn              (resetn),
      .dda_tick            (dda_tick),
      .loading_move        (loading_move),
      .executing_move      (executing_move),
      .increment           (increment[m]),
      .increment_increment (increment_increment[m]),
      .dir_bit             (dir[m]),
      .step                (step[m]),
      .position            (position[m])
    );
  end

endmodule

`default_nettype wire

// ==== tb_motion_core.sv ====
// Random self-checking testbench for motion_core; drives command words and checks replies and steps
`default_nettype none

`include "motion_defs.svh"

module tb_motion_core;
  timeunit 1ns;
  timeprecision 1ps;
  import motion_pkg::*;

  localparam int HALF_PERIOD   = 5;
  localparam int TICK_BUDGET   = 200;   // Upper bound on DDA ticks over all moves
  localparam int MAX_DIVISOR   = 5;
  localparam int MARGIN_CYCLES = 4000;  // Word transfers, reads and settling
  localparam int WATCHDOG_NS   = (TICK_BUDGET * MAX_DIVISOR + MARGIN_CYCLES) * 2 * HALF_PERIOD;

  logic        CLK = 1'b0;
  logic        resetn;
  logic        word_received;
  word_t       word_data_received;
  word_t       word_send_data;
  logic        buffer_dtr;
  logic        move_done;
  motor_mask_t step;
  motor_mask_t dir;
  motor_mask_t enable;

  integer      seed = 32'h380a6fb2;
  int          error_count = 0;
  int          check_count = 0;
  int          test_errors = 0;  // Errors before the current test
  int          cycle = 0;
  int          last_word_cycle;
  int          tick_div;
  int          move_count = 0;   // Accepted moves
  int          dir_checked = 0;
  int          exp_steps [`NUM_MOTORS];
  position_t   model_pos [`NUM_MOTORS] = '{default: '0};
  motor_mask_t move_dir [16];     // Header mask per accepted move
  rate_t       move_inc [`NUM_MOTORS];
  rate_t       move_ramp [`NUM_MOTORS];

  // Written by the monitor only
  int          done_count = 0;
  int          done_cycle;
  int          step_seen [`NUM_MOTORS];
  motor_mask_t step_dir [16];
  bit          step_dir_valid [16];

  motion_core UUT (
    .CLK                (CLK),
    .resetn             (resetn),
    .word_received      (word_received),
    .word_data_received (word_data_received),
    .word_send_data     (word_send_data),
    .buffer_dtr         (buffer_dtr),
    .move_done          (move_done),
    .step               (step),
    .dir                (dir),
    .enable             (enable)
  );

  always #HALF_PERIOD CLK = ~CLK;

  always @(posedge CLK) begin
    cycle <= cycle + 1;
  end

  // Outputs settle by mid-cycle
  always @(negedge CLK) begin
    if (resetn) begin
      for (int m = 0; m < `NUM_MOTORS; m++) begin
        if (step[m]) begin
          step_seen[m]++;
        end
      end
      if (step != '0) begin
        step_dir[done_count]       = dir;  // Move being executed
        step_dir_valid[done_count] = 1'b1;
      end
      if (move_done) begin
        done_count++;
        done_cycle = cycle;
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("Test failed");
    $finish;
  end

  task automatic check_word(input string name, input word_t got, input word_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_position(input string name, input position_t got, input position_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_mask(input string name, input motor_mask_t got, input motor_mask_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED at %0t ns: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED at %0t ns: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  // Carries of the unsigned accumulator over a number of ticks
  function automatic int count_steps(input rate_t inc, input rate_t ramp, input int ticks);
    logic [`DDA_BITS-1:0] acc;
    logic [`DDA_BITS-1:0] rate;
    logic [`DDA_BITS:0]   sum;
    int                   steps;
    acc   = '0;
    rate  = inc;
    steps = 0;
    for (int t = 0; t < ticks; t++) begin
      sum = {1'b0, acc} + {1'b0, rate};
      if (sum[`DDA_BITS]) begin
        steps++;
      end
      acc  = sum[`DDA_BITS-1:0];
      rate = rate + ramp;  // Ramp applies after the add
    end
    return steps;
  endfunction

  // 4 cycles high, 4 low, as the SPI core does
  task automatic send_word(input word_t w);
    @(negedge CLK);
    word_data_received = w;
    word_received      = 1'b1;
    last_word_cycle    = cycle;
    repeat (4) @(negedge CLK);
    word_received = 1'b0;
    repeat (4) @(negedge CLK);
  endtask

  task automatic read_status(input logic [7:0] addr, output word_t reply);
    word_t hdr;
    hdr = '0;
    hdr[`WORD_BITS-1 -: 8] = `CMD_STATUS_REG;
    hdr[7:0] = addr;
    send_word(hdr);
    reply = word_send_data;
    send_word('0);
  endtask

  // Reply comes from the header, the second word writes
  task automatic config_access(input logic [7:0] addr, input word_t wdata, output word_t reply);
    word_t hdr;
    hdr = '0;
    hdr[`WORD_BITS-1 -: 8] = `CMD_CONFIG_REG;
    hdr[7:0] = addr;
    send_word(hdr);
    reply = word_send_data;
    send_word(wdata);
  endtask

  task automatic set_divisor(input int d);
    word_t rd;
    config_access(8'd1, word_t'(divisor_t'(d)), rd);
    tick_div = d;
  endtask

  task automatic pick_rates(input logic ramped);
    for (int m = 0; m < `NUM_MOTORS; m++) begin
      move_inc[m] = rate_t'($random(seed));
      if (ramped) begin
        move_inc[m][`DDA_BITS-1 -: 4] = 4'b0001;  // Slow start
        move_ramp[m] = rate_t'($random(seed));
        move_ramp[m][`DDA_BITS-1 -: 8] = 8'h00;
        move_ramp[m][0] = 1'b1;
      end else begin
        move_inc[m][`DDA_BITS-1 -: 2] = 2'b01;  // A step every 2 to 4 ticks
        move_ramp[m] = '0;
      end
    end
  endtask

  task automatic send_move(input motor_mask_t mask, input int ticks);
    word_t hdr;
    hdr = '0;
    hdr[`WORD_BITS-1 -: 8] = `CMD_COORDINATED_STEP;
    hdr[`NUM_MOTORS-1:0] = mask;
    send_word(hdr);
    send_word(word_t'(duration_t'(ticks)));
    for (int m = 0; m < `NUM_MOTORS; m++) begin
      send_word(word_t'(move_inc[m]));
      send_word(word_t'(move_ramp[m]));
    end
  endtask

  task automatic model_move(input motor_mask_t mask, input int ticks);
    int s;
    for (int m = 0; m < `NUM_MOTORS; m++) begin
      s = count_steps(move_inc[m], move_ramp[m], ticks);
      exp_steps[m] += s;
      model_pos[m] = mask[m] ? model_pos[m] + position_t'(s) : model_pos[m] - position_t'(s);
    end
    move_dir[move_count] = mask;
    move_count++;
  endtask

  task automatic wait_moves_done(input int target, input int limit_cycles);
    int waited;
    waited = 0;
    while (done_count < target && waited < limit_cycles) begin
      @(posedge CLK);
      waited++;
    end
    if (done_count < target) begin
      error_count++;
      $display("[%0t] Timed out after %0d cycles waiting for move_done", $time, waited);
    end
  endtask

  task automatic run_move(input motor_mask_t mask, input int ticks);
    int target;
    target = done_count + 1;
    model_move(mask, ticks);
    send_move(mask, ticks);
    wait_moves_done(target, (ticks + 2) * tick_div + 60);
  endtask

  // Step counts, status positions and the dir seen during steps
  task automatic check_axes();
    word_t rd;
    for (int m = 0; m < `NUM_MOTORS; m++) begin
      check_position($sformatf("step count %0d", m), position_t'(step_seen[m]),
                     position_t'(exp_steps[m]));
      read_status(8'(2 + m), rd);
      check_position($sformatf("position %0d", m), position_t'(rd[`POSITION_BITS-1:0]),
                     model_pos[m]);
    end
    for (int i = dir_checked; i < done_count; i++) begin
      if (step_dir_valid[i]) begin
        check_mask($sformatf("dir of move %0d", i), step_dir[i], move_dir[i]);
      end
    end
    dir_checked = done_count;
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = error_count - test_errors;
    $display("[%0t] %s: %s, %0d errors", $time, name, (errs == 0) ? "ok" : "FAILED", errs);
    test_errors = error_count;
  endtask

  initial begin
    word_t       rd;
    word_t       exp;
    motor_mask_t mask;
    motor_mask_t en_val;
    divisor_t    div_val;
    int          ticks;
    int          total_ticks;
    int          first_done;
    int          latency;
    resetn             = 1'b0;
    word_received      = 1'b0;
    word_data_received = '0;
    tick_div           = `DEFAULT_DIVISOR;
    repeat (8) @(posedge CLK);
    @(negedge CLK);
    resetn = 1'b1;

    // Status words and reset state
    check_bit("buffer_dtr after reset", buffer_dtr, 1'b1);
    check_mask("enable after reset", enable, '0);
    read_status(8'd0, rd);
    exp = '0;
    exp[23:0] = {`VERSION_MAJOR, `VERSION_MINOR, `VERSION_PATCH};
    check_word("status version", rd, exp);
    read_status(8'd1, rd);
    exp = '0;
    exp[15:0] = {8'(`WORD_BITS), 8'(`NUM_MOTORS)};
    check_word("status channel info", rd, exp);
    read_status(8'(2 + `NUM_MOTORS) + 8'($random(seed) & 8'h7f), rd);
    check_word("status unknown index", rd, '0);
    end_test("status read");

    for (int i = 0; i < 4; i++) begin
      en_val  = motor_mask_t'($random(seed));
      div_val = divisor_t'($random(seed));
      config_access(8'd0, word_t'(en_val), rd);
      config_access(8'd1, word_t'(div_val), rd);
      config_access(8'd0, word_t'(en_val), rd);   // Read back, same value rewritten
      exp = '0;
      exp[`NUM_MOTORS-1:0] = en_val;
      check_word("config enable", rd, exp);
      config_access(8'd1, word_t'(div_val), rd);
      exp = '0;
      exp[`DIVISOR_BITS-1:0] = div_val;
      check_word("config divisor", rd, exp);
      check_mask("enable", enable, en_val);
    end
    config_access(8'd0, word_t'(motor_mask_t'({`NUM_MOTORS{1'b1}})), rd);
    check_mask("enable", enable, {`NUM_MOTORS{1'b1}});
    set_divisor(4);
    end_test("config access");

    mask  = motor_mask_t'($random(seed));
    ticks = 8 + ($random(seed) & 15);
    pick_rates(1'b0);
    run_move(mask, ticks);
    check_axes();
    end_test("single move");

    // Long first move keeps slot 0 busy while the rest arrive
    first_done  = done_count;
    mask        = motor_mask_t'($random(seed));
    ticks       = 40 + ($random(seed) & 7);
    total_ticks = ticks;
    pick_rates(1'b0);
    model_move(mask, ticks);
    send_move(mask, ticks);
    mask  = motor_mask_t'($random(seed));
    ticks = 8 + ($random(seed) & 7);
    total_ticks += ticks;
    pick_rates(1'b0);
    model_move(mask, ticks);
    send_move(mask, ticks);
    check_bit("buffer_dtr with both slots full", buffer_dtr, 1'b0);
    pick_rates(1'b0);
    send_move(~mask, 4);  // Dropped, not modelled
    wait_moves_done(first_done + 2, (total_ticks + 4) * tick_div + 100);
    repeat (10 * tick_div + 40) @(posedge CLK);
    if (done_count != first_done + 2) begin
      error_count++;
      $display("[%0t] Expected 2 move_done pulses but counted %0d", $time,
               done_count - first_done);
    end
    @(negedge CLK);
    check_bit("buffer_dtr after drain", buffer_dtr, 1'b1);
    check_axes();
    end_test("back to back moves");

    mask  = motor_mask_t'($random(seed));
    ticks = 16 + ($random(seed) & 15);
    pick_rates(1'b1);
    run_move(mask, ticks);
    check_axes();
    end_test("ramped move");

    set_divisor(2 + ($random(seed) & 3));
    mask  = motor_mask_t'($random(seed));
    ticks = 4 + ($random(seed) & 7);
    pick_rates(1'b0);
    run_move(mask, ticks);
    latency = done_cycle - last_word_cycle;
    if (latency < ticks * tick_div || latency > (ticks + 1) * tick_div + 4) begin
      error_count++;
      $display("[%0t] move_done came %0d cycles after the last word, outside %0d to %0d",
               $time, latency, ticks * tick_div, (ticks + 1) * tick_div + 4);
    end
    check_axes();
    end_test("move timing");

    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
motion_pkg.sv
spi_command_decoder.sv
move_buffer.sv
move_sequencer.sv
dda_timer.sv
motion_core.sv
tb_motion_core.sv

// ==== Makefile ====
TOP   = tb_motion_core
BUILD = obj_dir
LOG   = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
